// ==== hdl/life_pkg.sv ====
package life_pkg;

    // board geometry
    localparam int BOARD_SIDE  = 8;
    localparam int BOARD_CELLS = BOARD_SIDE * BOARD_SIDE;

    // line s sits in bits 8s..8s+7, cell (s, r) is bit 8s+r
    typedef logic [BOARD_CELLS-1:0] board_t;
    typedef logic [BOARD_SIDE-1:0]  line_t;
    typedef logic [2:0]             scan_t;

    // selectable start patterns
    typedef enum logic [1:0] {
        PAT_OCTAGON = 2'd0,
        PAT_BLINKER = 2'd1,
        PAT_GLIDER  = 2'd2,
        PAT_BLOCK   = 2'd3
    } pattern_t;

    // seed board for a given pattern
    function automatic board_t seed_board(input pattern_t pat);
        board_t b;
        b = '0;
        case (pat)
            PAT_OCTAGON: begin
                // symmetric ring, same either bit order
                b = 64'b00011000_00100100_01000010_10000001_10000001_01000010_00100100_00011000;
            end
            PAT_BLINKER: begin
                // three in a row on line 3
                b[3*BOARD_SIDE + 3] = 1'b1;
                b[3*BOARD_SIDE + 4] = 1'b1;
                b[3*BOARD_SIDE + 5] = 1'b1;
            end
            PAT_GLIDER: begin
                b[0*BOARD_SIDE + 1] = 1'b1;
                b[1*BOARD_SIDE + 2] = 1'b1;
                b[2*BOARD_SIDE + 0] = 1'b1;
                b[2*BOARD_SIDE + 1] = 1'b1;
                b[2*BOARD_SIDE + 2] = 1'b1;
            end
            default: begin
                // 2x2 still life in the middle
                b[3*BOARD_SIDE + 3] = 1'b1;
                b[3*BOARD_SIDE + 4] = 1'b1;
                b[4*BOARD_SIDE + 3] = 1'b1;
                b[4*BOARD_SIDE + 4] = 1'b1;
            end
        endcase
        return b;
    endfunction

endpackage

// ==== hdl/cell_array.sv ====
`timescale 1ns/1ps

module cell_array import life_pkg::*; (
    input  board_t board,
    output board_t next_board
);

    // state of cell (s, r), zero when off the board
    function automatic logic [3:0] alive_at(input board_t b, input int s, input int r);
        logic [3:0] v;
        v = 4'd0;
        if (s >= 0 && s < BOARD_SIDE && r >= 0 && r < BOARD_SIDE) begin
            v = {3'b000, b[s*BOARD_SIDE + r]};
        end
        return v;
    endfunction

    // one rule slice per cell
    for (genvar s = 0; s < BOARD_SIDE; s++) begin : g_line
        for (genvar r = 0; r < BOARD_SIDE; r++) begin : g_cell
            logic [3:0] neighbors;
            logic       alive;

            assign alive = board[s*BOARD_SIDE + r];

            // eight surrounding cells, no wrap at the edges
            assign neighbors = alive_at(board, s - 1, r - 1)
                             + alive_at(board, s - 1, r)
                             + alive_at(board, s - 1, r + 1)
                             + alive_at(board, s,     r - 1)
                             + alive_at(board, s,     r + 1)
                             + alive_at(board, s + 1, r - 1)
                             + alive_at(board, s + 1, r)
                             + alive_at(board, s + 1, r + 1);

            // birth on three, survival on two or three
            assign next_board[s*BOARD_SIDE + r] = (neighbors == 4'd3) ||
                                                  (alive && (neighbors == 4'd2));
        end
    end

endmodule

// ==== hdl/generation_timer.sv ====
`timescale 1ns/1ps

module generation_timer #(
    parameter int GEN_PERIOD = 1000
) (
    input  logic clk,
    input  logic reset,
    output logic gen_pulse
);

    localparam int CNT_W = $clog2(GEN_PERIOD);
    localparam logic [CNT_W-1:0] LAST     = CNT_W'(GEN_PERIOD - 1);
    localparam logic [CNT_W-1:0] PRE_LAST = CNT_W'(GEN_PERIOD - 2);

    logic [CNT_W-1:0] count;

    // free running count, wraps after the pulse cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            count     <= '0;
            gen_pulse <= 1'b0;
        end else begin
            if (count == LAST) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
            // pulse registered so it lines up with count == LAST
            gen_pulse <= (count == PRE_LAST);
        end
    end

    // strobe is a single cycle wide
    a_pulse_single: assert property (@(posedge clk) disable iff (reset)
        gen_pulse |=> !gen_pulse);

endmodule

// ==== hdl/scan_counter.sv ====
`timescale 1ns/1ps

module scan_counter import life_pkg::*; #(
    parameter int SCAN_DIV = 1
) (
    input  logic  clk,
    input  logic  reset,
    output scan_t scan_index
);

    // prescaler needs at least one bit even for SCAN_DIV of 1
    localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCAN_DIV - 1);

    logic [DIV_W-1:0] prescale;

    always_ff @(posedge clk) begin
        if (reset) begin
            prescale   <= '0;
            scan_index <= '0;
        end else if (prescale == DIV_LAST) begin
            prescale   <= '0;
            // 3-bit index wraps 7 -> 0 by itself
            scan_index <= scan_index + 1'b1;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

endmodule

// ==== hdl/board_register.sv ====
`timescale 1ns/1ps

module board_register import life_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     run,
    input  pattern_t pattern,
    input  logic     gen_pulse,
    input  board_t   next_board,
    output board_t   board
);

    logic advance;

    // step only on a strobe while running
    assign advance = gen_pulse && run;

    // seed on reset, next generation on advance, otherwise hold
    always_ff @(posedge clk) begin
        if (reset) begin
            board <= seed_board(pattern);
        end else if (advance) begin
            board <= next_board;
        end
    end

    // no strobe, no change
    a_hold_no_pulse: assert property (@(posedge clk)
        (!reset && !gen_pulse) |=> $stable(board));

endmodule

// ==== hdl/matrix_driver.sv ====
`timescale 1ns/1ps

module matrix_driver import life_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  scan_t                 scan_index,
    input  board_t                board,
    output line_t                 rows_out,
    output logic [BOARD_SIDE-1:0] columns_out
);

    logic [BOARD_SIDE-1:0] column_sel;
    line_t                 line_sel;

    // one-hot column select from the scan index
    assign column_sel = {{(BOARD_SIDE-1){1'b0}}, 1'b1} << scan_index;

    // current line of the board
    assign line_sel = board[scan_index*BOARD_SIDE +: BOARD_SIDE];

    // both outputs registered in the same edge so they stay aligned
    always_ff @(posedge clk) begin
        if (reset) begin
            // all LEDs dark
            columns_out <= '0;
            rows_out    <= '1;
        end else begin
            columns_out <= column_sel;
            // rows sink current, so a live cell drives low
            rows_out    <= ~line_sel;
        end
    end

    // at most one column lit
    a_columns_onehot0: assert property (@(posedge clk)
        $onehot0(columns_out));

endmodule

// ==== hdl/life_matrix.sv ====
`timescale 1ns/1ps

module life_matrix import life_pkg::*; #(
    // clocks between generations
    parameter int GEN_PERIOD = 12_000_000,
    // clocks per displayed line
    parameter int SCAN_DIV   = 1500
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  run,
    input  pattern_t              pattern,
    output line_t                 rows_out,
    output logic [BOARD_SIDE-1:0] columns_out
);

    logic   gen_pulse;
    scan_t  scan_index;
    board_t board;
    board_t next_board;

    // generation strobe
    generation_timer #(
        .GEN_PERIOD(GEN_PERIOD)
    ) gen_timer0 (
        .clk      (clk),
        .reset    (reset),
        .gen_pulse(gen_pulse)
    );

    // line scan for the display
    scan_counter #(
        .SCAN_DIV(SCAN_DIV)
    ) scan0 (
        .clk       (clk),
        .reset     (reset),
        .scan_index(scan_index)
    );

    // live board state
    board_register board0 (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .pattern   (pattern),
        .gen_pulse (gen_pulse),
        .next_board(next_board),
        .board     (board)
    );

    // life rule
    cell_array cells0 (
        .board     (board),
        .next_board(next_board)
    );

    // led matrix outputs
    matrix_driver driver0 (
        .clk        (clk),
        .reset      (reset),
        .scan_index (scan_index),
        .board      (board),
        .rows_out   (rows_out),
        .columns_out(columns_out)
    );

endmodule

// ==== tests/tb_life_matrix.sv ====
`timescale 1ns/1ps

module tb_life_matrix import life_pkg::*; ();

    localparam int          CLK_PERIOD       = 100;
    localparam int          GEN_PERIOD       = 40;
    localparam int          SCAN_DIV         = 1;
    localparam int          NUM_EPISODES     = 12;
    localparam int          GENS_PER_EPISODE = 6;
    localparam int          MARGIN_CYCLES    = NUM_EPISODES * 20 + 200;
    localparam int          WATCHDOG_CYCLES  =
        NUM_EPISODES * GENS_PER_EPISODE * GEN_PERIOD + MARGIN_CYCLES;
    localparam int unsigned RAND_SEED        = 32'h24eb_6ac8;

    logic                  clk;
    logic                  reset;
    logic                  run;
    pattern_t              pattern;
    line_t                 rows_out;
    logic [BOARD_SIDE-1:0] columns_out;

    // model state
    board_t                m_board;
    int                    m_count;
    scan_t                 m_scan;
    int                    m_div;
    logic [BOARD_SIDE-1:0] exp_columns;
    line_t                 exp_rows;
    logic                  model_valid;

    int                    rows_errors;
    int                    columns_errors;
    int                    board_errors;
    int                    other_errors;

    life_matrix #(
        .GEN_PERIOD(GEN_PERIOD),
        .SCAN_DIV  (SCAN_DIV)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .pattern    (pattern),
        .rows_out   (rows_out),
        .columns_out(columns_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // start boards, written out cell by cell
    function automatic board_t expected_seed(input pattern_t pat);
        board_t b;
        b = '0;
        case (pat)
            // octagon ring, same shape read from either end
            PAT_OCTAGON: b = {8'h18, 8'h24, 8'h42, 8'h81, 8'h81, 8'h42, 8'h24, 8'h18};
            PAT_BLINKER: begin
                b[3*8 + 3] = 1'b1;
                b[3*8 + 4] = 1'b1;
                b[3*8 + 5] = 1'b1;
            end
            PAT_GLIDER: begin
                b[0*8 + 1] = 1'b1;
                b[1*8 + 2] = 1'b1;
                b[2*8 + 0] = 1'b1;
                b[2*8 + 1] = 1'b1;
                b[2*8 + 2] = 1'b1;
            end
            default: begin
                b[3*8 + 3] = 1'b1;
                b[3*8 + 4] = 1'b1;
                b[4*8 + 3] = 1'b1;
                b[4*8 + 4] = 1'b1;
            end
        endcase
        return b;
    endfunction

    // one generation, off-board neighbors are dead
    function automatic board_t life_step(input board_t b);
        board_t n;
        int     cnt;
        int     ns;
        int     nr;
        n = '0;
        for (int s = 0; s < 8; s++) begin
            for (int r = 0; r < 8; r++) begin
                cnt = 0;
                for (int ds = -1; ds <= 1; ds++) begin
                    for (int dr = -1; dr <= 1; dr++) begin
                        ns = s + ds;
                        nr = r + dr;
                        if ((ds != 0 || dr != 0) && ns >= 0 && ns < 8 && nr >= 0 && nr < 8) begin
                            cnt += b[ns*8 + nr];
                        end
                    end
                end
                n[s*8 + r] = (cnt == 3) || (b[s*8 + r] && cnt == 2);
            end
        end
        return n;
    endfunction

    // reference model, same edge the DUT samples on
    always @(posedge clk) begin
        if (reset) begin
            m_board     <= expected_seed(pattern);
            m_count     <= 0;
            m_scan      <= 3'd0;
            m_div       <= 0;
            exp_columns <= '0;
            exp_rows    <= '1;
            model_valid <= 1'b1;
        end else begin
            // outputs lag the index and board by one clock
            exp_columns <= {{(BOARD_SIDE-1){1'b0}}, 1'b1} << m_scan;
            exp_rows    <= ~m_board[m_scan*8 +: 8];
            // strobe is up while the count sits at its last value
            if (m_count == GEN_PERIOD - 1 && run) begin
                m_board <= life_step(m_board);
            end
            m_count <= (m_count == GEN_PERIOD - 1) ? 0 : m_count + 1;
            if (m_div == SCAN_DIV - 1) begin
                m_div  <= 0;
                m_scan <= m_scan + 3'd1;
            end else begin
                m_div <= m_div + 1;
            end
        end
    end

    task automatic check_rows(input line_t expected, input line_t actual);
        if (actual !== expected) begin
            rows_errors++;
            $display("FAILED rows_out: expected 0x%h, got 0x%h at %0t", expected, actual, $time);
        end
    endtask

    task automatic check_columns(input logic [BOARD_SIDE-1:0] expected,
                                 input logic [BOARD_SIDE-1:0] actual);
        if (actual !== expected) begin
            columns_errors++;
            $display("FAILED columns_out: expected 0x%h, got 0x%h at %0t",
                     expected, actual, $time);
        end
    endtask

    task automatic check_board(input board_t expected, input board_t actual);
        if (actual !== expected) begin
            board_errors++;
            $display("FAILED board: expected 0x%h, got 0x%h at %0t", expected, actual, $time);
        end
    endtask

    // outputs settled mid-cycle
    always @(negedge clk) begin
        if (model_valid) begin
            check_columns(exp_columns, columns_out);
            check_rows(exp_rows, rows_out);
        end
    end

    task automatic apply_reset(output pattern_t chosen);
        @(posedge clk);
        chosen = pattern_t'($urandom_range(0, 3));
        reset   <= 1'b1;
        pattern <= chosen;
        run     <= 1'b1;
        // four edges with reset high
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    endtask

    // rebuild the board from one pass of the display
    task automatic scan_board(output board_t seen);
        int idx;
        seen = '0;
        repeat (8) begin
            @(posedge clk);
            @(negedge clk);
            idx = -1;
            for (int i = 0; i < BOARD_SIDE; i++) begin
                if (columns_out[i]) begin
                    idx = i;
                end
            end
            if (idx < 0) begin
                other_errors++;
                $display("no column lit during the scan at %0t", $time);
            end else begin
                seen[idx*8 +: 8] = ~rows_out;
            end
        end
    endtask

    task automatic report_counts();
        $display("errors: rows_out %0d, columns_out %0d, board %0d, other %0d",
                 rows_errors, columns_errors, board_errors, other_errors);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        other_errors++;
        $display("timeout: run did not finish within %0d clocks", WATCHDOG_CYCLES);
        report_counts();
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        pattern_t chosen;
        board_t   seen;
        int       run_cycles;
        void'($urandom(RAND_SEED));
        reset          = 1'b1;
        run            = 1'b0;
        pattern        = PAT_OCTAGON;
        model_valid    = 1'b0;
        rows_errors    = 0;
        columns_errors = 0;
        board_errors   = 0;
        other_errors   = 0;
        for (int ep = 0; ep < NUM_EPISODES; ep++) begin
            apply_reset(chosen);
            $display("episode %0d, pattern %s", ep, chosen.name());
            scan_board(seen);
            check_board(expected_seed(chosen), seen);
            // random length, so later resets land mid-run
            run_cycles = $urandom_range(GEN_PERIOD, GENS_PER_EPISODE * GEN_PERIOD);
            repeat (run_cycles) begin
                @(posedge clk);
                // keep run steady next to a pulse edge
                if (m_count != GEN_PERIOD - 2 && m_count != GEN_PERIOD - 1 &&
                    $urandom_range(0, 7) == 0) begin
                    run <= ($urandom_range(0, 3) != 0);
                end
            end
        end
        @(posedge clk);
        @(negedge clk);
        report_counts();
        if (rows_errors + columns_errors + board_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== life_matrix.f ====
hdl/life_pkg.sv
hdl/cell_array.sv
hdl/generation_timer.sv
hdl/scan_counter.sv
hdl/board_register.sv
hdl/matrix_driver.sv
hdl/life_matrix.sv
tests/tb_life_matrix.sv

// ==== Makefile ====
# Verilator build and run for the life matrix testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_life_matrix
FILELIST  ?= life_matrix.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TEST PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
